// File: compile.f
design/heap_pkg.sv
design/heap_bram.sv
design/heap_alloc.sv
design/heap_arbiter.sv
design/heap_top.sv
bench/heap_asserts.sv
bench/heap_tb.sv

// File: Makefile
# Verilator build and run for the heap testbench

VERILATOR ?= verilator
TOP       ?= heap_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
LOG       ?= sim.log
FAIL_MSG  ?= Simulation failed
VFLAGS    ?= --binary --timing --assert -Wall -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/heap_tb.sv
/*
 * heap testbench
 * directed tests against a queue-based heap model, two clients
 */
`timescale 1ns/10ps

module heap_tb;
    import heap_pkg::*;

    logic                   i_clk = 1'b0;
    logic                   i_arst_n;
    logic                   i_c0_valid;
    logic                   i_c1_valid;
    heap_op_e               i_c0_op;
    heap_op_e               i_c1_op;
    logic [HEAP_DATA_W-1:0] i_c0_addr;
    logic [HEAP_DATA_W-1:0] i_c0_data;
    logic [HEAP_DATA_W-1:0] i_c1_addr;
    logic [HEAP_DATA_W-1:0] i_c1_data;
    logic                   o_c0_ready;
    logic                   o_c0_rsp_valid;
    logic                   o_c1_ready;
    logic                   o_c1_rsp_valid;
    logic [HEAP_DATA_W-1:0] o_c0_rsp_data;
    logic [HEAP_DATA_W-1:0] o_c1_rsp_data;
    logic                   o_err;

    // reference model
    int                     top_m;
    logic [HEAP_DATA_W-1:0] free_q[$];              // LIFO, back is head
    logic [HEAP_DATA_W-1:0] cells [HEAP_DEPTH];
    int                     err_cnt = 0;
    int                     n_pass = 0;
    int                     n_fail = 0;

    heap_top heap_top_inst (.*);

    always #2 i_clk = ~i_clk;   // 4 ns period

    function automatic logic [HEAP_DATA_W-1:0] tag_ptr(input int idx);
        tag_ptr = 16'h5000 | 16'(idx);   // tag nibble 5, index in low bits
    endfunction

    function automatic logic ready_of(input int c);
        ready_of = c ? o_c1_ready : o_c0_ready;
    endfunction

    function automatic logic rsp_v(input int c);
        rsp_v = c ? o_c1_rsp_valid : o_c0_rsp_valid;
    endfunction

    function automatic logic [HEAP_DATA_W-1:0] rsp_d(input int c);
        rsp_d = c ? o_c1_rsp_data : o_c0_rsp_data;
    endfunction

    task automatic check_eq(input string name, input logic [HEAP_DATA_W-1:0] exp,
                            input logic [HEAP_DATA_W-1:0] act);
        if (exp !== act) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic set_req(input int c, input logic v, input heap_op_e op,
                           input logic [HEAP_DATA_W-1:0] a, input logic [HEAP_DATA_W-1:0] d);
        if (c == 0) begin
            i_c0_valid = v;
            i_c0_op    = op;
            i_c0_addr  = a;
            i_c0_data  = d;
        end else begin
            i_c1_valid = v;
            i_c1_op    = op;
            i_c1_addr  = a;
            i_c1_data  = d;
        end
    endtask

    // called just after a falling edge, returns just after one
    task automatic do_req(input int c, input heap_op_e op, input logic [HEAP_DATA_W-1:0] a,
                          input logic [HEAP_DATA_W-1:0] d, output logic [HEAP_DATA_W-1:0] rsp);
        int t;
        t = 0;
        rsp = 'x;
        set_req(c, 1'b1, op, a, d);
        #1;
        while (!ready_of(c) && t < 50) begin
            #4;
            t++;
        end
        if (!ready_of(c)) begin
            $display("timeout: client %0d never saw ready", c);
            err_cnt++;
            @(negedge i_clk);
            set_req(c, 1'b0, op, a, d);
        end else begin
            @(negedge i_clk);   // accepted on the rising edge in between
            set_req(c, 1'b0, op, a, d);
            t = 0;
            while (!rsp_v(c) && t < 50) begin
                @(negedge i_clk);
                t++;
            end
            if (!rsp_v(c)) begin
                $display("timeout: client %0d got no response", c);
                err_cnt++;
            end else begin
                if (t != 0) begin
                    $display("FAIL t=%0t o_c%0d_rsp_valid late by %0d cycles", $time, c, t);
                    err_cnt++;
                end
                rsp = rsp_d(c);
            end
        end
    endtask

    task automatic alloc_chk(input int c, input logic [HEAP_DATA_W-1:0] d);
        logic [HEAP_DATA_W-1:0] exp, rsp;
        if (free_q.size() > 0) begin
            exp = free_q.pop_back();   // newest freed cell first
        end else begin
            exp = tag_ptr(top_m);
            top_m++;
        end
        cells[exp[HEAP_ADDR_W-1:0]] = d;
        do_req(c, OP_ALLOC, '0, d, rsp);
        check_eq($sformatf("o_c%0d_rsp_data", c), exp, rsp);
    endtask

    task automatic write_chk(input int c, input logic [HEAP_DATA_W-1:0] a,
                             input logic [HEAP_DATA_W-1:0] d);
        logic [HEAP_DATA_W-1:0] rsp;
        cells[a[HEAP_ADDR_W-1:0]] = d;
        do_req(c, OP_WRITE, a, d, rsp);
        check_eq($sformatf("o_c%0d_rsp_data", c), UNIT, rsp);
    endtask

    task automatic read_chk(input int c, input logic [HEAP_DATA_W-1:0] a);
        logic [HEAP_DATA_W-1:0] rsp;
        do_req(c, OP_READ, a, '0, rsp);
        check_eq($sformatf("o_c%0d_rsp_data", c), cells[a[HEAP_ADDR_W-1:0]], rsp);
    endtask

    task automatic free_chk(input int c, input logic [HEAP_DATA_W-1:0] a);
        logic [HEAP_DATA_W-1:0] rsp;
        free_q.push_back(a);
        do_req(c, OP_FREE, a, '0, rsp);
        check_eq($sformatf("o_c%0d_rsp_data", c), UNIT, rsp);
    endtask

    // faulting request: accepted, no response, halt
    task automatic err_req(input int c, input heap_op_e op, input logic [HEAP_DATA_W-1:0] a);
        int t;
        t = 0;
        set_req(c, 1'b1, op, a, '0);
        #1;
        while (!ready_of(c) && t < 50) begin
            #4;
            t++;
        end
        if (!ready_of(c)) begin
            $display("timeout: client %0d never saw ready before the fault", c);
            err_cnt++;
        end
        @(negedge i_clk);
        if (rsp_v(c)) begin
            $display("FAIL t=%0t o_c%0d_rsp_valid expected 0 got 1", $time, c);
            err_cnt++;
        end
        check_bit("o_err", 1'b1, o_err);
        repeat (3) @(negedge i_clk);   // keep asking, must stay blocked
        set_req(1 - c, 1'b1, OP_ALLOC, '0, '0);
        #1;
        check_bit("o_c0_ready", 1'b0, o_c0_ready);
        check_bit("o_c1_ready", 1'b0, o_c1_ready);
        check_bit("o_err", 1'b1, o_err);
        @(negedge i_clk);
        set_req(0, 1'b0, OP_ALLOC, '0, '0);
        set_req(1, 1'b0, OP_ALLOC, '0, '0);
    endtask

    task automatic reset_dut();
        set_req(0, 1'b0, OP_ALLOC, '0, '0);
        set_req(1, 1'b0, OP_ALLOC, '0, '0);
        i_arst_n = 1'b0;
        repeat (5) @(negedge i_clk);
        i_arst_n = 1'b1;
        top_m = 0;
        free_q.delete();
        @(negedge i_clk);
    endtask

    task automatic report(input string name, input int e0);
        if (err_cnt == e0) begin
            $display("test %s: ok", name);
            n_pass++;
        end else begin
            $display("test %s: %0d errors", name, err_cnt - e0);
            n_fail++;
        end
    endtask

    task automatic fresh_alloc();
        int e0;
        e0 = err_cnt;
        for (int i = 0; i < 5; i++) begin
            alloc_chk(0, 16'($urandom));   // 5000 upward
        end
        for (int i = 0; i < 5; i++) begin
            read_chk(0, tag_ptr(i));
        end
        report("fresh_alloc", e0);
    endtask

    task automatic write_then_read();
        int e0;
        e0 = err_cnt;
        for (int i = 0; i < 5; i++) begin
            write_chk(1, tag_ptr(i), 16'($urandom));
        end
        for (int i = 4; i >= 0; i--) begin
            read_chk(1, tag_ptr(i));
        end
        write_chk(1, tag_ptr(2), 16'($urandom));   // back to back with the read
        read_chk(1, tag_ptr(2));
        report("write_read", e0);
    endtask

    task automatic free_list_reuse();
        int e0;
        e0 = err_cnt;
        free_chk(0, tag_ptr(1));
        free_chk(0, tag_ptr(3));
        free_chk(0, tag_ptr(0));
        for (int i = 0; i < 4; i++) begin
            alloc_chk(0, 16'($urandom));   // 3 reused, then top (5)
        end
        for (int i = 0; i < 6; i++) begin
            read_chk(0, tag_ptr(i));
        end
        report("free_reuse", e0);
    endtask

    task automatic client_contention();
        int   e0;
        int   t;
        int   acc0;
        int   acc1;
        int   n0;
        int   n1;
        int   last;
        logic pend0;
        logic pend1;
        int   a0[4];
        int   a1[4];
        e0 = err_cnt;
        a0 = '{0, 1, 2, 3};
        a1 = '{5, 4, 3, 2};
        t = 0;
        acc0 = 0;
        acc1 = 0;
        n0 = 0;
        n1 = 0;
        last = -1;
        pend0 = 1'b0;
        pend1 = 1'b0;
        @(negedge i_clk);   // let the previous response pulse pass
        while ((n0 < 4 || n1 < 4) && t < 50) begin
            if (o_c0_rsp_valid !== pend0 || o_c1_rsp_valid !== pend1) begin
                $display("response pulse not one cycle after acceptance at t=%0t", $time);
                err_cnt++;
            end
            if (o_c0_rsp_valid && n0 < 4) begin
                check_eq("o_c0_rsp_data", cells[a0[n0]], o_c0_rsp_data);
                n0++;
            end
            if (o_c1_rsp_valid && n1 < 4) begin
                check_eq("o_c1_rsp_data", cells[a1[n1]], o_c1_rsp_data);
                n1++;
            end
            set_req(0, acc0 < 4, OP_READ, tag_ptr(a0[acc0 % 4]), '0);
            set_req(1, acc1 < 4, OP_READ, tag_ptr(a1[acc1 % 4]), '0);
            #1;
            pend0 = i_c0_valid && o_c0_ready;
            pend1 = i_c1_valid && o_c1_ready;
            if (i_c0_valid && i_c1_valid && (pend0 || pend1) && last == int'(pend1)) begin
                $display("grant did not alternate at t=%0t", $time);
                err_cnt++;
            end
            if (pend0) begin
                acc0++;
                last = 0;
            end
            if (pend1) begin
                acc1++;
                last = 1;
            end
            @(negedge i_clk);
            t++;
        end
        if (n0 < 4 || n1 < 4) begin
            $display("timeout: contention got %0d and %0d responses", n0, n1);
            err_cnt++;
        end
        set_req(0, 1'b0, OP_READ, '0, '0);
        set_req(1, 1'b0, OP_READ, '0, '0);
        report("contention", e0);
    endtask

    task automatic out_of_memory();
        int e0;
        e0 = err_cnt;
        reset_dut();
        for (int i = 0; i < HEAP_DEPTH; i++) begin
            alloc_chk(0, 16'($urandom));
        end
        err_req(0, OP_ALLOC, '0);   // 65th
        reset_dut();
        check_bit("o_err", 1'b0, o_err);
        alloc_chk(1, 16'($urandom));   // restarts at 5000
        report("out_of_memory", e0);
    endtask

    task automatic bad_address();
        int e0;
        e0 = err_cnt;
        reset_dut();
        alloc_chk(0, 16'($urandom));
        alloc_chk(0, 16'($urandom));
        err_req(1, OP_READ, 16'h8003);   // wrong tag
        reset_dut();
        alloc_chk(0, 16'($urandom));
        alloc_chk(0, 16'($urandom));
        err_req(0, OP_FREE, tag_ptr(3));   // above top
        reset_dut();
        report("invalid_address", e0);
    endtask

    initial begin
        void'($urandom(97));
        reset_dut();
        fresh_alloc();
        write_then_read();
        free_list_reuse();
        client_contention();
        out_of_memory();
        bad_address();
        $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // hard limit on run time
    initial begin
        #200000;
        $display("run stopped, overall time limit reached");
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: bench/heap_asserts.sv
/*
 * heap protocol checks
 * response timing, one response at a time, sticky halt
 */
`timescale 1ns/10ps

module heap_asserts (
    input logic i_clk,
    input logic i_arst_n,
    input logic i_c0_valid,
    input logic i_c1_valid,
    input logic o_c0_ready,
    input logic o_c1_ready,
    input logic o_c0_rsp_valid,
    input logic o_c1_rsp_valid,
    input logic o_err
);

    // acceptance at N gives a pulse at N+1
    a_rsp_c0: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_c0_valid && o_c0_ready && !o_err) |=> (o_c0_rsp_valid || o_err))
        else $error("c0 response missing after acceptance");
    a_rsp_c1: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_c1_valid && o_c1_ready && !o_err) |=> (o_c1_rsp_valid || o_err))
        else $error("c1 response missing after acceptance");

    // a pulse goes to one client only, the one accepted a cycle earlier
    a_one_rsp: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (o_c0_rsp_valid || o_c1_rsp_valid) |->
            (o_c0_rsp_valid ? (!o_c1_rsp_valid && $past(i_c0_valid && o_c0_ready))
                            : $past(i_c1_valid && o_c1_ready)))
        else $error("response pulse without acceptance or on both clients");

    a_err_sticky: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_err |=> o_err)
        else $error("o_err dropped without reset");

    a_halt: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_err |-> (!o_c0_ready && !o_c1_ready))
        else $error("ready high while halted");

endmodule

bind heap_top heap_asserts heap_asserts_inst (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_c0_valid     (i_c0_valid),
    .i_c1_valid     (i_c1_valid),
    .o_c0_ready     (o_c0_ready),
    .o_c1_ready     (o_c1_ready),
    .o_c0_rsp_valid (o_c0_rsp_valid),
    .o_c1_rsp_valid (o_c1_rsp_valid),
    .o_err          (o_err)
);

// File: design/heap_top.sv
/*
 * tagged-pointer heap top level
 * two client ports through the arbiter into the allocator and its cell RAM
 */
`timescale 1ns/10ps

module heap_top (
    input  logic                             i_clk,
    input  logic                             i_arst_n,
    input  logic                             i_c0_valid,
    input  heap_pkg::heap_op_e               i_c0_op,
    input  logic [heap_pkg::HEAP_DATA_W-1:0] i_c0_addr,
    input  logic [heap_pkg::HEAP_DATA_W-1:0] i_c0_data,
    output logic                             o_c0_ready,
    output logic                             o_c0_rsp_valid,
    output logic [heap_pkg::HEAP_DATA_W-1:0] o_c0_rsp_data,
    input  logic                             i_c1_valid,
    input  heap_pkg::heap_op_e               i_c1_op,
    input  logic [heap_pkg::HEAP_DATA_W-1:0] i_c1_addr,
    input  logic [heap_pkg::HEAP_DATA_W-1:0] i_c1_data,
    output logic                             o_c1_ready,
    output logic                             o_c1_rsp_valid,
    output logic [heap_pkg::HEAP_DATA_W-1:0] o_c1_rsp_data,
    output logic                             o_err
);
    import heap_pkg::*;

    // shared request/response between arbiter and allocator
    logic                   req_valid;
    logic                   req_ready;
    heap_op_e               req_op;
    logic [HEAP_DATA_W-1:0] req_addr;
    logic [HEAP_DATA_W-1:0] req_data;
    logic                   rsp_valid;
    logic [HEAP_DATA_W-1:0] rsp_data;

    // allocator to RAM
    logic                   wr_en;
    logic [HEAP_ADDR_W-1:0] waddr;
    logic [HEAP_DATA_W-1:0] wdata;
    logic                   rd_en;
    logic [HEAP_ADDR_W-1:0] raddr;
    logic [HEAP_DATA_W-1:0] rdata;

    heap_arbiter heap_arbiter_inst (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_c0_valid     (i_c0_valid),
        .i_c0_op        (i_c0_op),
        .i_c0_addr      (i_c0_addr),
        .i_c0_data      (i_c0_data),
        .o_c0_ready     (o_c0_ready),
        .o_c0_rsp_valid (o_c0_rsp_valid),
        .o_c0_rsp_data  (o_c0_rsp_data),
        .i_c1_valid     (i_c1_valid),
        .i_c1_op        (i_c1_op),
        .i_c1_addr      (i_c1_addr),
        .i_c1_data      (i_c1_data),
        .o_c1_ready     (o_c1_ready),
        .o_c1_rsp_valid (o_c1_rsp_valid),
        .o_c1_rsp_data  (o_c1_rsp_data),
        .o_req_valid    (req_valid),
        .i_req_ready    (req_ready),
        .o_req_op       (req_op),
        .o_req_addr     (req_addr),
        .o_req_data     (req_data),
        .i_rsp_valid    (rsp_valid),
        .i_rsp_data     (rsp_data)
    );

    heap_alloc heap_alloc_inst (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_req_valid (req_valid),
        .o_req_ready (req_ready),
        .i_req_op    (req_op),
        .i_req_addr  (req_addr),
        .i_req_data  (req_data),
        .o_rsp_valid (rsp_valid),
        .o_rsp_data  (rsp_data),
        .o_err       (o_err),
        .o_wr_en     (wr_en),
        .o_waddr     (waddr),
        .o_wdata     (wdata),
        .o_rd_en     (rd_en),
        .o_raddr     (raddr),
        .i_rdata     (rdata)
    );

    heap_bram heap_bram_inst (
        .i_clk   (i_clk),
        .i_wr_en (wr_en),
        .i_waddr (waddr),
        .i_wdata (wdata),
        .i_rd_en (rd_en),
        .i_raddr (raddr),
        .o_rdata (rdata)
    );

endmodule

// File: design/heap_arbiter.sv
/*
 * two-client round-robin arbiter
 * combinational grant, response steered back to the last accepted client
 */
`timescale 1ns/10ps

module heap_arbiter (
    input  logic                             i_clk,
    input  logic                             i_arst_n,
    input  logic                             i_c0_valid,
    input  heap_pkg::heap_op_e               i_c0_op,
    input  logic [heap_pkg::HEAP_DATA_W-1:0] i_c0_addr,
    input  logic [heap_pkg::HEAP_DATA_W-1:0] i_c0_data,
    output logic                             o_c0_ready,
    output logic                             o_c0_rsp_valid,
    output logic [heap_pkg::HEAP_DATA_W-1:0] o_c0_rsp_data,
    input  logic                             i_c1_valid,
    input  heap_pkg::heap_op_e               i_c1_op,
    input  logic [heap_pkg::HEAP_DATA_W-1:0] i_c1_addr,
    input  logic [heap_pkg::HEAP_DATA_W-1:0] i_c1_data,
    output logic                             o_c1_ready,
    output logic                             o_c1_rsp_valid,
    output logic [heap_pkg::HEAP_DATA_W-1:0] o_c1_rsp_data,
    output logic                             o_req_valid,
    input  logic                             i_req_ready,
    output heap_pkg::heap_op_e               o_req_op,
    output logic [heap_pkg::HEAP_DATA_W-1:0] o_req_addr,
    output logic [heap_pkg::HEAP_DATA_W-1:0] o_req_data,
    input  logic                             i_rsp_valid,
    input  logic [heap_pkg::HEAP_DATA_W-1:0] i_rsp_data
);

    logic last_q;   // 1 = c1 granted last, also owner of the pending response
    logic sel;      // 1 = c1 wins this cycle

    // c1 wins when alone, or when both ask and c0 went last
    assign sel = i_c1_valid && (!i_c0_valid || !last_q);

    assign o_req_valid = i_c0_valid || i_c1_valid;
    assign o_req_op    = sel ? i_c1_op   : i_c0_op;
    assign o_req_addr  = sel ? i_c1_addr : i_c0_addr;
    assign o_req_data  = sel ? i_c1_data : i_c0_data;

    // only the winner sees ready
    assign o_c0_ready = i_req_ready && i_c0_valid && !sel;
    assign o_c1_ready = i_req_ready && sel;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            last_q <= 1'b0;
        end else if (o_req_valid && i_req_ready) begin
            last_q <= sel;   // moves on acceptance only
        end
    end

    // response pulse goes to the client accepted one cycle earlier
    assign o_c0_rsp_valid = i_rsp_valid && !last_q;
    assign o_c1_rsp_valid = i_rsp_valid && last_q;
    assign o_c0_rsp_data  = i_rsp_data;   // qualified by rsp_valid
    assign o_c1_rsp_data  = i_rsp_data;

endmodule

// File: design/heap_alloc.sv
/*
 * heap allocator
 * serves alloc/free/write/read with a LIFO free list linked through the cells,
 * a top-of-heap marker and a sticky error halt; fixed 1-cycle response
 */
`timescale 1ns/10ps

module heap_alloc (
    input  logic                             i_clk,
    input  logic                             i_arst_n,
    input  logic                             i_req_valid,
    output logic                             o_req_ready,
    input  heap_pkg::heap_op_e               i_req_op,
    input  logic [heap_pkg::HEAP_DATA_W-1:0] i_req_addr,
    input  logic [heap_pkg::HEAP_DATA_W-1:0] i_req_data,
    output logic                             o_rsp_valid,
    output logic [heap_pkg::HEAP_DATA_W-1:0] o_rsp_data,
    output logic                             o_err,
    output logic                             o_wr_en,
    output logic [heap_pkg::HEAP_ADDR_W-1:0] o_waddr,
    output logic [heap_pkg::HEAP_DATA_W-1:0] o_wdata,
    output logic                             o_rd_en,
    output logic [heap_pkg::HEAP_ADDR_W-1:0] o_raddr,
    input  logic [heap_pkg::HEAP_DATA_W-1:0] i_rdata
);
    import heap_pkg::*;

    logic [HEAP_CNT_W-1:0]  top_q;        // next never-used index
    logic [HEAP_DATA_W-1:0] head_q;       // free-list head, tagged or NIL
    logic [HEAP_CNT_W-1:0]  free_cnt_q;   // cells on free list
    logic                   pop_q;        // head arrives from RAM this cycle
    logic                   run_q;        // ready, low in reset and once halted
    logic                   err_q;
    logic                   rsp_valid_q;
    logic                   rsp_rd_q;     // response carries RAM data
    logic [HEAP_DATA_W-1:0] rsp_data_q;   // alloc pointer or UNIT

    logic [HEAP_DATA_W-1:0] head_cur;
    logic [HEAP_DATA_W-1:0] alloc_ptr;
    logic                   acc;
    logic                   ok;
    logic                   is_alloc;
    logic                   is_free;
    logic                   is_read;
    logic                   pop;
    logic                   oom;
    logic                   addr_bad;
    logic                   err_set;

    assign acc      = i_req_valid && run_q;
    assign is_alloc = (i_req_op == OP_ALLOC);
    assign is_free  = (i_req_op == OP_FREE);
    assign is_read  = (i_req_op == OP_READ);

    // bypass: popped link is still in the RAM output register
    assign head_cur = pop_q ? i_rdata : head_q;

    assign pop = is_alloc && (free_cnt_q != '0);   // reuse a freed cell
    assign oom = (free_cnt_q == '0) && top_q[HEAP_ADDR_W];   // top hit HEAP_DEPTH

    // tag must match, offset must be below the top marker
    assign addr_bad = ((i_req_addr & HEAP_TAG_MASK) != HEAP_TAG) ||
                      (i_req_addr[HEAP_OFS_W-1:0] >=
                       {{(HEAP_OFS_W - HEAP_CNT_W){1'b0}}, top_q});

    assign err_set = acc && (is_alloc ? oom : addr_bad);
    assign ok      = acc && !err_set;   // request that gets served

    assign alloc_ptr = pop ? head_cur : heap_ptr(top_q[HEAP_ADDR_W-1:0]);

    // RAM port steering
    always_comb begin
        o_wr_en = ok && !is_read;          // alloc, free and write all store
        o_rd_en = ok && (is_read || pop);  // pop fetches the next link
        o_waddr = i_req_addr[HEAP_ADDR_W-1:0];
        o_raddr = i_req_addr[HEAP_ADDR_W-1:0];
        o_wdata = i_req_data;
        if (is_alloc) begin
            o_waddr = alloc_ptr[HEAP_ADDR_W-1:0];
            o_raddr = head_cur[HEAP_ADDR_W-1:0];   // old word = link
        end else if (is_free) begin
            o_wdata = head_cur;                    // freed cell links to old head
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            top_q       <= '0;
            head_q      <= NIL;
            free_cnt_q  <= '0;
            pop_q       <= 1'b0;
            run_q       <= 1'b0;
            err_q       <= 1'b0;
            rsp_valid_q <= 1'b0;
            rsp_rd_q    <= 1'b0;
        end else begin
            rsp_valid_q <= ok;   // faulting request gets no response
            rsp_rd_q    <= ok && is_read;
            pop_q       <= ok && pop;
            head_q      <= head_cur;   // capture link from RAM
            run_q       <= !(err_q || err_set);
            if (err_set) begin
                err_q <= 1'b1;   // sticky until reset
            end
            if (ok && is_alloc) begin
                if (pop) begin
                    free_cnt_q <= free_cnt_q - 1'b1;
                end else begin
                    top_q <= top_q + 1'b1;   // raise the ceiling
                end
            end
            if (ok && is_free) begin
                head_q     <= i_req_addr;
                free_cnt_q <= free_cnt_q + 1'b1;
            end
        end
    end

    // response payload
    always_ff @(posedge i_clk) begin
        if (ok) begin
            rsp_data_q <= is_alloc ? alloc_ptr : UNIT;
        end
    end

    assign o_req_ready = run_q;
    assign o_err       = err_q;
    assign o_rsp_valid = rsp_valid_q;
    assign o_rsp_data  = rsp_rd_q ? i_rdata : rsp_data_q;   // read data same cycle

endmodule

// File: design/heap_bram.sv
/*
 * heap cell RAM
 * one write port, one registered read port, read returns old word on collision
 */
`timescale 1ns/10ps

module heap_bram (
    input  logic                             i_clk,
    input  logic                             i_wr_en,
    input  logic [heap_pkg::HEAP_ADDR_W-1:0] i_waddr,
    input  logic [heap_pkg::HEAP_DATA_W-1:0] i_wdata,
    input  logic                             i_rd_en,
    input  logic [heap_pkg::HEAP_ADDR_W-1:0] i_raddr,
    output logic [heap_pkg::HEAP_DATA_W-1:0] o_rdata
);
    import heap_pkg::*;

    logic [HEAP_DATA_W-1:0] mem [HEAP_DEPTH];   // cell storage

    // write port
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // read port, holds last word when idle
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            o_rdata <= mem[i_raddr];   // sees pre-write contents
        end
    end

endmodule

// File: design/heap_pkg.sv
/*
 * heap allocator shared definitions
 * widths, tag and reserved words, request opcodes, pointer helper
 */
package heap_pkg;

    // sizes
    localparam int HEAP_DATA_W = 16;                 // data word and tagged pointer
    localparam int HEAP_ADDR_W = 6;                  // cell index
    localparam int HEAP_DEPTH  = 1 << HEAP_ADDR_W;   // 64 cells
    localparam int HEAP_CNT_W  = HEAP_ADDR_W + 1;    // top/count reach HEAP_DEPTH
    localparam int HEAP_OFS_W  = HEAP_DATA_W - 4;    // bits below the tag nibble

    // tag space, upper nibble of a word
    localparam logic [HEAP_DATA_W-1:0] HEAP_TAG_MASK = 16'hF000;
    localparam logic [HEAP_DATA_W-1:0] HEAP_TAG      = 16'h5000;  // mutable + volatile

    // reserved values
    localparam logic [HEAP_DATA_W-1:0] NIL  = 16'h0001;  // empty free-list link
    localparam logic [HEAP_DATA_W-1:0] UNIT = 16'h0004;  // inert result

    // request opcodes
    typedef enum logic [1:0] {
        OP_ALLOC = 2'd0,   // reserve cell, store initial value
        OP_FREE  = 2'd1,   // push cell onto free list
        OP_WRITE = 2'd2,
        OP_READ  = 2'd3
    } heap_op_e;

    // tagged pointer for a cell index
    function automatic logic [HEAP_DATA_W-1:0] heap_ptr(
        input logic [HEAP_ADDR_W-1:0] idx
    );
        heap_ptr = HEAP_TAG | {{(HEAP_DATA_W - HEAP_ADDR_W){1'b0}}, idx};
    endfunction

endpackage
